/* hdl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // datapath width
    localparam int XLEN = 64;

    // operand candidates seen by the ALU
    localparam int BYPASS_WID = 4;
    localparam int CAND_IDX_W = 2;

    // candidate slots, fixed by construction
    localparam logic [CAND_IDX_W-1:0] CAND_RF0 = 2'd0;
    localparam logic [CAND_IDX_W-1:0] CAND_RF1 = 2'd1;
    localparam logic [CAND_IDX_W-1:0] CAND_IMM = 2'd2;
    localparam logic [CAND_IDX_W-1:0] CAND_BYP = 2'd3;

    // two integer sources per micro-op
    localparam int NUM_SRCS = 2;

    localparam int ROB_IDX_W = 5;
    localparam int PREG_W = 6;

    typedef enum logic [3:0] {
        op_lui  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_addw = 4'd3,
        op_subw = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_sllw = 4'd8,
        op_srlw = 4'd9,
        op_sraw = 4'd10,
        op_xor  = 4'd11,
        op_or   = 4'd12,
        op_and  = 4'd13,
        op_slt  = 4'd14,
        op_sltu = 4'd15
    } mic_op_t;

    // ALU control, 16 bits
    typedef struct packed {
        mic_op_t                mic_op;
        logic [ROB_IDX_W-1:0]   rob_idx;
        logic [PREG_W-1:0]      iprd_idx;
        logic                   iprd_wen;
    } fu_info_t;

    // one issued instruction
    typedef struct packed {
        fu_info_t               fu_info;
        logic [PREG_W-1:0]      src0_preg;
        logic [PREG_W-1:0]      src1_preg;
        logic                   use_imm;
        logic [31:0]            imm;
    } issue_pkt_t;

    // writeback record, 76 bits
    typedef struct packed {
        logic [ROB_IDX_W-1:0]   rob_idx;
        logic                   iprd_wen;
        logic [PREG_W-1:0]      iprd_idx;
        logic [XLEN-1:0]        wb_data;
    } wb_info_t;

    // register file write port, 71 bits
    typedef struct packed {
        logic                   wen;
        logic [PREG_W-1:0]      waddr;
        logic [XLEN-1:0]        wdata;
    } rf_wr_t;

    // sign-extend a 32-bit value to XLEN
    function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

endpackage

`default_nettype wire

/* hdl/phys_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module phys_regfile
    import exec_pkg::*;
#(
    parameter int NUM_PREG = 64
)(
    input  wire                 clk,
    input  wire                 rst,
    // read ports
    input  wire [PREG_W-1:0]    i_rd_idx0,
    input  wire [PREG_W-1:0]    i_rd_idx1,
    output logic [XLEN-1:0]     o_rd_data0,
    output logic [XLEN-1:0]     o_rd_data1,
    // write port
    input  wire rf_wr_t         i_wr
);

    logic [XLEN-1:0] regs [NUM_PREG];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREG; i++) begin
                regs[i] <= '0;
            end
        end
        else if (i_wr.wen && (i_wr.waddr != '0)) begin
            regs[i_wr.waddr] <= i_wr.wdata;
        end
    end

    // combinational reads, x0 reads as zero
    always_comb begin
        o_rd_data0 = (i_rd_idx0 == '0) ? '0 : regs[i_rd_idx0];
        o_rd_data1 = (i_rd_idx1 == '0) ? '0 : regs[i_rd_idx1];
    end

    // writeback wiring must filter x0 before it gets here
    a_no_wr_x0: assert property (
        @(posedge clk) disable iff (rst)
        !(i_wr.wen && (i_wr.waddr == '0))
    ) else $error("phys_regfile: write enabled to register 0");

endmodule

`default_nettype wire

/* hdl/operand_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_fetch
    import exec_pkg::*;
#(
    parameter int NUM_PREG = 64
)(
    input  wire                                     clk,
    input  wire                                     rst,
    // issue side
    input  wire                                     i_issue_vld,
    input  wire issue_pkt_t                         i_issue,
    input  wire                                     i_stall,
    // register file read
    output logic [PREG_W-1:0]                       o_rd_idx0,
    output logic [PREG_W-1:0]                       o_rd_idx1,
    input  wire [XLEN-1:0]                          i_rd_data0,
    input  wire [XLEN-1:0]                          i_rd_data1,
    // last result from the writeback register
    input  wire [XLEN-1:0]                          i_bypass_data,
    // to the ALU
    output logic [NUM_SRCS-1:0][CAND_IDX_W-1:0]     o_data_idx,
    output logic [BYPASS_WID-1:0][XLEN-1:0]         o_cand_data
);

    logic               issue_acc;
    logic               pend_vld;
    logic [PREG_W-1:0]  pend_idx;
    logic [PREG_W-1:0]  src0_q;
    logic [PREG_W-1:0]  src1_q;
    logic [31:0]        imm_q;
    logic               hit0;
    logic               hit1;

    assign issue_acc = i_issue_vld && !i_stall;

    // pending destination tracks the instruction in the ALU capture stage
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_vld <= 1'b0;
        end
        else if (!i_stall) begin
            pend_vld <= issue_acc && i_issue.fu_info.iprd_wen
                        && (i_issue.fu_info.iprd_idx != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (issue_acc) begin
            pend_idx <= i_issue.fu_info.iprd_idx;
            src0_q   <= i_issue.src0_preg;
            src1_q   <= i_issue.src1_preg;
            imm_q    <= i_issue.imm;
        end
    end

    // a source that matches the result about to land takes the bypass
    assign hit0 = pend_vld && (i_issue.src0_preg == pend_idx);
    assign hit1 = pend_vld && (i_issue.src1_preg == pend_idx);

    always_comb begin
        o_data_idx[0] = hit0 ? CAND_BYP : CAND_RF0;
        if (i_issue.use_imm) begin
            o_data_idx[1] = CAND_IMM;
        end
        else if (hit1) begin
            o_data_idx[1] = CAND_BYP;
        end
        else begin
            o_data_idx[1] = CAND_RF1;
        end
    end

    // sources are read in the execute cycle
    assign o_rd_idx0 = src0_q;
    assign o_rd_idx1 = src1_q;

    always_comb begin
        o_cand_data[CAND_RF0] = i_rd_data0;
        o_cand_data[CAND_RF1] = i_rd_data1;
        o_cand_data[CAND_IMM] = sext32(imm_q);
        o_cand_data[CAND_BYP] = i_bypass_data;
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (rst)
        issue_acc |-> (o_data_idx[0] < BYPASS_WID) && (o_data_idx[1] < BYPASS_WID)
    ) else $error("operand_fetch: bad candidate index at issue");

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu
    import exec_pkg::*;
(
    input  wire                                     clk,
    input  wire                                     rst,
    // control
    input  wire                                     i_has_vld,
    input  wire fu_info_t                           i_fu_info,
    output logic                                    o_fu_stall,
    // operand candidates and the chosen slots
    input  wire [BYPASS_WID-1:0][XLEN-1:0]          i_data,
    input  wire [NUM_SRCS-1:0][CAND_IDX_W-1:0]      i_data_idx,
    // writeback
    input  wire                                     i_wb_stall,
    output logic                                    o_complete,
    output wb_info_t                                o_wb_info
);

    logic                                   cap_vld;
    fu_info_t                               cap_info;
    logic [NUM_SRCS-1:0][CAND_IDX_W-1:0]    cap_idx;

    logic [XLEN-1:0]    src0;
    logic [XLEN-1:0]    src1;
    logic [5:0]         shamt;
    logic [4:0]         shamt_w;
    logic [XLEN-1:0]    add_r;
    logic [XLEN-1:0]    sub_r;
    logic [31:0]        sllw_r;
    logic [31:0]        srlw_r;
    logic [31:0]        sraw_r;
    logic [XLEN-1:0]    calc_data;

    // no internal hazards, stall comes straight from writeback
    assign o_fu_stall = i_wb_stall;

    // capture stage
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_vld <= 1'b0;
        end
        else if (!i_wb_stall) begin
            cap_vld <= i_has_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_has_vld && !i_wb_stall) begin
            cap_info <= i_fu_info;
            cap_idx  <= i_data_idx;
        end
    end

    // operand select
    assign src0 = i_data[cap_idx[0]];
    assign src1 = i_data[cap_idx[1]];

    assign shamt   = src1[5:0];
    assign shamt_w = src1[4:0];

    assign add_r = src0 + src1;
    assign sub_r = src0 - src1;

    // word shifts only see the low half
    assign sllw_r = src0[31:0] << shamt_w;
    assign srlw_r = src0[31:0] >> shamt_w;
    assign sraw_r = $signed(src0[31:0]) >>> shamt_w;

    always_comb begin
        case (cap_info.mic_op)
            op_lui: begin
                calc_data = {{(XLEN-32){src1[19]}}, src1[19:0], 12'b0};
            end
            op_add: begin
                calc_data = add_r;
            end
            op_sub: begin
                calc_data = sub_r;
            end
            op_addw: begin
                calc_data = sext32(add_r[31:0]);
            end
            op_subw: begin
                calc_data = sext32(sub_r[31:0]);
            end
            op_sll: begin
                calc_data = src0 << shamt;
            end
            op_srl: begin
                calc_data = src0 >> shamt;
            end
            op_sra: begin
                calc_data = $signed(src0) >>> shamt;
            end
            op_sllw: begin
                calc_data = sext32(sllw_r);
            end
            op_srlw: begin
                calc_data = sext32(srlw_r);
            end
            op_sraw: begin
                calc_data = sext32(sraw_r);
            end
            op_xor: begin
                calc_data = src0 ^ src1;
            end
            op_or: begin
                calc_data = src0 | src1;
            end
            op_and: begin
                calc_data = src0 & src1;
            end
            op_slt: begin
                calc_data = {{(XLEN-1){1'b0}}, $signed(src0) < $signed(src1)};
            end
            default: begin
                // sltu
                calc_data = {{(XLEN-1){1'b0}}, src0 < src1};
            end
        endcase
    end

    // writeback register, held while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            o_complete <= 1'b0;
        end
        else if (!i_wb_stall) begin
            o_complete <= cap_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_wb_stall) begin
            o_wb_info.rob_idx  <= cap_info.rob_idx;
            o_wb_info.iprd_wen <= cap_info.iprd_wen;
            o_wb_info.iprd_idx <= cap_info.iprd_idx;
            o_wb_info.wb_data  <= calc_data;
        end
    end

    a_no_issue_stalled: assert property (
        @(posedge clk) disable iff (rst)
        i_has_vld |-> !o_fu_stall
    ) else $error("alu: issue while stalled");

    a_wb_hold: assert property (
        @(posedge clk) disable iff (rst)
        (o_complete && i_wb_stall) |=> (o_complete && $stable(o_wb_info))
    ) else $error("alu: stalled record changed");

endmodule

`default_nettype wire

/* hdl/int_exec_top.sv */
`timescale 1ns/100ps
`default_nettype none

module int_exec_top
    import exec_pkg::*;
#(
    parameter int NUM_PREG = 64
)(
    input  wire                 clk,
    input  wire                 rst,
    // issue
    input  wire                 i_issue_vld,
    input  wire issue_pkt_t     i_issue,
    output logic                o_fu_stall,
    // writeback
    input  wire                 i_wb_stall,
    output logic                o_complete,
    output wb_info_t            o_wb_info
);

    logic [PREG_W-1:0]                      rd_idx0;
    logic [PREG_W-1:0]                      rd_idx1;
    logic [XLEN-1:0]                        rd_data0;
    logic [XLEN-1:0]                        rd_data1;
    logic [NUM_SRCS-1:0][CAND_IDX_W-1:0]    data_idx;
    logic [BYPASS_WID-1:0][XLEN-1:0]        cand_data;
    logic                                   wb_accept;
    rf_wr_t                                 rf_wr;

    // register index width has to cover the register file
    if (NUM_PREG != (1 << PREG_W)) begin : g_preg_check
        $error("int_exec_top: NUM_PREG does not match PREG_W");
    end

    operand_fetch #(
        .NUM_PREG       (NUM_PREG)
    ) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .i_issue_vld    (i_issue_vld),
        .i_issue        (i_issue),
        .i_stall        (o_fu_stall),
        .o_rd_idx0      (rd_idx0),
        .o_rd_idx1      (rd_idx1),
        .i_rd_data0     (rd_data0),
        .i_rd_data1     (rd_data1),
        .i_bypass_data  (o_wb_info.wb_data),
        .o_data_idx     (data_idx),
        .o_cand_data    (cand_data)
    );

    alu u_alu (
        .clk            (clk),
        .rst            (rst),
        .i_has_vld      (i_issue_vld),
        .i_fu_info      (i_issue.fu_info),
        .o_fu_stall     (o_fu_stall),
        .i_data         (cand_data),
        .i_data_idx     (data_idx),
        .i_wb_stall     (i_wb_stall),
        .o_complete     (o_complete),
        .o_wb_info      (o_wb_info)
    );

    // record leaves in the cycle it is accepted, x0 writes dropped here
    assign wb_accept = o_complete && !i_wb_stall;

    always_comb begin
        rf_wr.wen   = wb_accept && o_wb_info.iprd_wen && (o_wb_info.iprd_idx != '0);
        rf_wr.waddr = o_wb_info.iprd_idx;
        rf_wr.wdata = o_wb_info.wb_data;
    end

    phys_regfile #(
        .NUM_PREG       (NUM_PREG)
    ) u_regfile (
        .clk            (clk),
        .rst            (rst),
        .i_rd_idx0      (rd_idx0),
        .i_rd_idx1      (rd_idx1),
        .o_rd_data0     (rd_data0),
        .o_rd_data1     (rd_data1),
        .i_wr           (rf_wr)
    );

endmodule

`default_nettype wire

/* dv/int_exec_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module int_exec_tb
    import exec_pkg::*;
();

    localparam int NUM_PREG = 64;
    localparam logic [PREG_W-1:0] X0 = '0;
    // scratch register used when loading 64-bit constants
    localparam logic [PREG_W-1:0] SCR = 6'd1;

    typedef logic [127:0] cval_t;

    logic           clk;
    logic           rst;
    logic           i_issue_vld;
    issue_pkt_t     i_issue;
    logic           i_wb_stall;
    logic           o_fu_stall;
    logic           o_complete;
    wb_info_t       o_wb_info;

    logic [XLEN-1:0]        mdl_rf [NUM_PREG];
    wb_info_t               exp_q[$];
    int                     iss_cyc_q[$];
    int                     iss_stall_q[$];
    logic [ROB_IDX_W-1:0]   next_rob;
    int                     seed;
    int                     n_issued;
    int                     cyc;
    int                     stall_cnt;
    logic                   hold_prev;
    wb_info_t               prev_info;
    string                  cur_test;

    int_exec_top #(
        .NUM_PREG       (NUM_PREG)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .i_issue_vld    (i_issue_vld),
        .i_issue        (i_issue),
        .o_fu_stall     (o_fu_stall),
        .i_wb_stall     (i_wb_stall),
        .o_complete     (o_complete),
        .o_wb_info      (o_wb_info)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // limit grows with the number of issued instructions
    initial begin : watchdog
        int wd_cyc;
        wd_cyc = 0;
        while (wd_cyc <= 20 * n_issued + 200) begin
            @(posedge clk);
            wd_cyc++;
        end
        $display("timeout after %0d cycles, %0d issued, %0d records outstanding",
                 wd_cyc, n_issued, exp_q.size());
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input string what, input cval_t exp_v, input cval_t act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [XLEN-1:0] sign_ext_word(input logic [31:0] w);
        return {{(XLEN-32){w[31]}}, w};
    endfunction

    // RV64 semantics where b is the second operand or the immediate
    function automatic logic [XLEN-1:0] model_alu(input mic_op_t op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            op_lui:  return sign_ext_word({b[19:0], 12'h000});
            op_add:  return a + b;
            op_sub:  return a - b;
            op_addw: return sign_ext_word(a[31:0] + b[31:0]);
            op_subw: return sign_ext_word(a[31:0] - b[31:0]);
            op_sll:  return a << b[5:0];
            op_srl:  return a >> b[5:0];
            op_sra:  return $signed(a) >>> b[5:0];
            op_sllw: return sign_ext_word(a[31:0] << b[4:0]);
            op_srlw: return sign_ext_word(a[31:0] >> b[4:0]);
            op_sraw: return sign_ext_word($signed(a[31:0]) >>> b[4:0]);
            op_xor:  return a ^ b;
            op_or:   return a | b;
            op_and:  return a & b;
            op_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return (a < b) ? 64'd1 : 64'd0;
        endcase
    endfunction

    task automatic step(input logic vld, input issue_pkt_t pkt, input logic stall);
        @(posedge clk);
        i_issue_vld <= vld;
        i_issue     <= pkt;
        i_wb_stall  <= stall;
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, 1'b0);
    endtask

    // predicts the record, updates the model, then drives one issue cycle
    task automatic issue(input mic_op_t op, input logic [PREG_W-1:0] rd, input logic wen,
                         input logic [PREG_W-1:0] s0, input logic [PREG_W-1:0] s1,
                         input logic use_imm, input logic [31:0] imm);
        issue_pkt_t pkt;
        wb_info_t   rec;
        pkt.fu_info.mic_op   = op;
        pkt.fu_info.rob_idx  = next_rob;
        pkt.fu_info.iprd_idx = rd;
        pkt.fu_info.iprd_wen = wen;
        pkt.src0_preg        = s0;
        pkt.src1_preg        = s1;
        pkt.use_imm          = use_imm;
        pkt.imm              = imm;
        rec.rob_idx  = next_rob;
        rec.iprd_wen = wen;
        rec.iprd_idx = rd;
        rec.wb_data  = model_alu(op, mdl_rf[s0], use_imm ? sign_ext_word(imm) : mdl_rf[s1]);
        if (wen && (rd != X0)) begin
            mdl_rf[rd] = rec.wb_data;
        end
        exp_q.push_back(rec);
        next_rob++;
        n_issued++;
        step(1'b1, pkt, 1'b0);
    endtask

    // lui and add build the upper half while shifts zero-extend the lower half
    task automatic load_reg(input logic [PREG_W-1:0] rd, input logic [XLEN-1:0] v);
        issue(op_lui, rd, 1'b1, X0, X0, 1'b1, {12'h000, v[63:44]});
        issue(op_add, rd, 1'b1, rd, X0, 1'b1, {20'h00000, v[43:32]});
        issue(op_sll, rd, 1'b1, rd, X0, 1'b1, 32'd32);
        issue(op_add, SCR, 1'b1, X0, X0, 1'b1, v[31:0]);
        issue(op_sll, SCR, 1'b1, SCR, X0, 1'b1, 32'd32);
        issue(op_srl, SCR, 1'b1, SCR, X0, 1'b1, 32'd32);
        issue(op_or, rd, 1'b1, rd, SCR, 1'b0, 32'd0);
    endtask

    task automatic test_reset();
        cur_test = "reset";
        @(negedge clk);
        check_val("o_complete", '0, cval_t'(o_complete));
        for (int r = 0; r < NUM_PREG; r += 2) begin
            issue(op_or, PREG_W'(r), 1'b0, PREG_W'(r), PREG_W'(r + 1), 1'b0, 32'd0);
        end
        idle(4);
    endtask

    task automatic test_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        cur_test = "alu_ops";
        for (int k = 1; k < 16; k++) begin
            for (int t = 0; t < 6; t++) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                if (t == 0) begin
                    // amount above 31 for the 64-bit shifts
                    b = 64'd45;
                end
                if (t == 1) begin
                    a = 64'hffff_ffff_ffff_fff9;
                    b = 64'd3;
                end
                if (t == 2) begin
                    a = 64'h0000_0000_7fff_ffff;
                    b = 64'd1;
                end
                load_reg(6'd10, a);
                load_reg(6'd11, b);
                issue(mic_op_t'(k), 6'd12, 1'b1, 6'd10, 6'd11, 1'b0, 32'd0);
            end
            issue(mic_op_t'(k), 6'd13, 1'b1, 6'd12, X0, 1'b1, $random(seed));
        end
        for (int t = 0; t < 6; t++) begin
            issue(op_lui, 6'd14, 1'b1, X0, X0, 1'b1, $random(seed));
        end
        idle(4);
    endtask

    task automatic test_chain();
        cur_test = "bypass_chain";
        load_reg(6'd20, {$random(seed), $random(seed)});
        load_reg(6'd5, {$random(seed), $random(seed)});
        for (int i = 0; i < 10; i++) begin
            issue(op_add, PREG_W'(21 + i), 1'b1, PREG_W'(20 + i),
                  (i % 2 == 0) ? 6'd5 : PREG_W'(20 + i), 1'b0, 32'd0);
        end
        idle(4);
    endtask

    // the monitor checks the age of every record
    task automatic test_latency();
        cur_test = "latency";
        for (int i = 0; i < 4; i++) begin
            issue(op_add, 6'd15, 1'b1, 6'd15, X0, 1'b1, 32'd3);
            idle(3 + i);
        end
        for (int i = 0; i < 8; i++) begin
            issue(op_xor, PREG_W'(16 + i % 4), 1'b1, 6'd15, PREG_W'(16 + (i + 1) % 4),
                  1'b0, 32'd0);
        end
        idle(4);
    endtask

    task automatic test_stall_stream();
        logic [PREG_W-1:0] rd;
        logic [PREG_W-1:0] s0;
        logic [PREG_W-1:0] last_rd;
        mic_op_t           op;
        cur_test = "stall_stream";
        last_rd = 6'd10;
        for (int i = 0; i < 80; i++) begin
            while (($random(seed) & 3) == 0) begin
                step(1'b0, '0, 1'b1);
            end
            op = mic_op_t'($random(seed) & 15);
            rd = PREG_W'(2 + ($random(seed) & 31));
            s0 = (($random(seed) & 1) == 1) ? last_rd : PREG_W'($random(seed) & 31);
            issue(op, rd, 1'b1, s0, PREG_W'($random(seed) & 31),
                  (op == op_lui) || (($random(seed) & 3) == 0), $random(seed));
            last_rd = rd;
        end
        // stall pulses while the pipe drains
        for (int i = 0; i < 6; i++) begin
            step(1'b0, '0, i[0]);
        end
        idle(4);
    endtask

    task automatic test_no_write();
        cur_test = "no_write";
        load_reg(6'd7, 64'h1234_5678_9abc_def0);
        issue(op_add, 6'd7, 1'b0, X0, X0, 1'b1, 32'h0bad_0001);
        issue(op_add, X0, 1'b1, X0, X0, 1'b1, 32'h0bad_0002);
        issue(op_or, 6'd8, 1'b1, 6'd7, X0, 1'b0, 32'd0);
        idle(3);
        issue(op_or, 6'd8, 1'b1, 6'd7, X0, 1'b0, 32'd0);
        issue(op_add, 6'd9, 1'b1, X0, X0, 1'b0, 32'd0);
        idle(4);
    endtask

    always @(negedge clk) begin : monitor
        wb_info_t exp_rec;
        if (!rst) begin
            check_val("o_fu_stall", cval_t'(i_wb_stall), cval_t'(o_fu_stall));
            if (hold_prev) begin
                check_val("held o_complete", cval_t'(1'b1), cval_t'(o_complete));
                check_val("held record", cval_t'(prev_info), cval_t'(o_wb_info));
            end
            if (i_issue_vld && !i_wb_stall) begin
                iss_cyc_q.push_back(cyc);
                iss_stall_q.push_back(stall_cnt);
            end
            if (o_complete && !i_wb_stall) begin
                if (exp_q.size() == 0) begin
                    $display("record rob %0d completed with no instruction outstanding",
                             o_wb_info.rob_idx);
                    $display("Simulation FAILED");
                    $fatal(1, "unexpected completion");
                end
                exp_rec = exp_q.pop_front();
                check_val("record", cval_t'(exp_rec), cval_t'(o_wb_info));
                check_val("latency", cval_t'(2 + stall_cnt - iss_stall_q.pop_front()),
                          cval_t'(cyc - iss_cyc_q.pop_front()));
            end
            if (i_wb_stall) begin
                stall_cnt++;
            end
            hold_prev = o_complete && i_wb_stall;
            prev_info = o_wb_info;
        end
        cyc++;
    end

    initial begin
        seed        = 34;
        n_issued    = 0;
        cyc         = 0;
        stall_cnt   = 0;
        hold_prev   = 1'b0;
        next_rob    = '0;
        cur_test    = "init";
        rst         = 1'b1;
        i_issue_vld = 1'b0;
        i_issue     = '0;
        i_wb_stall  = 1'b0;
        for (int r = 0; r < NUM_PREG; r++) begin
            mdl_rf[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_ops();
        test_chain();
        test_latency();
        test_stall_stream();
        test_no_write();
        while (exp_q.size() != 0) begin
            step(1'b0, '0, 1'b0);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/exec_pkg.sv
hdl/phys_regfile.sv
hdl/operand_fetch.sv
hdl/alu.sv
hdl/int_exec_top.sv
dv/int_exec_tb.sv

/* Makefile */
SIM      = verilator
TOP      = int_exec_tb
FILELIST = sources.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir

.PHONY: sim clean

# build and run, a $fatal in the run gives a non-zero exit status
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)_sim
	./$(OBJDIR)/$(TOP)_sim

clean:
	rm -rf $(OBJDIR)
